// File: verilog.f
+incdir+.
blockmix_pkg.sv
salsa_round.sv
salsa_core.sv
blockmix_dp.sv
blockmix_ctrl.sv
blockmix.sv
blockmix_asserts.sv
blockmix_clk_gen.sv
blockmix_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module blockmix_tb -o blockmix_sim

if ! ./obj_dir/blockmix_sim +verilator+error+limit+1000 > sim.log 2>&1; then
	cat sim.log
	echo "simulator exited with an error"
	exit 1
fi
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0

// File: blockmix_tb.sv
// blockmix testbench; results are checked by the bound assertion module, stimulus only
`timescale 1ns/1ps
`default_nettype none

`include "blockmix_defs.svh"

module blockmix_tb
	import blockmix_pkg::*;
();

	localparam int num_random = 20;
	// zero block, random blocks, and the busy-start pair
	localparam int num_runs = num_random + 2;
	localparam int max_cycles = 40 * num_runs + 100;

	logic clk;
	logic reset_n;
	logic start;
	bm_data_t data_in;
	bm_data_t data_out;
	logic done;

	logic [31:0] lfsr_state;
	int cycle_cnt;

	blockmix_clk_gen clk_gen_inst (
		.clk(clk),
		.reset_n(reset_n)
	);

	blockmix blockmix_inst (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.data_in(data_in),
		.data_out(data_out),
		.done(done)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_block(output bm_data_t blk);
		blk = '0;
		for (int i = 0; i < 2 * `BM_BLOCK_WORDS * `BM_WORD_W; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			blk[i] = lfsr_state[0];
		end
	endtask

	// data_in is scrambled right after the pulse, so only the start cycle counts
	task automatic pulse_start(input bm_data_t blk);
		@(negedge clk);
		start = 1'b1;
		data_in = blk;
		@(negedge clk);
		start = 1'b0;
		data_in = ~blk;
	endtask

	task automatic wait_done();
		while (!done) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic run_block(input bm_data_t blk);
		pulse_start(blk);
		wait_done();
	endtask

	task automatic close_run(input int timeouts);
		int fails;
		fails = blockmix_inst.asserts_inst.fail_cnt;
		$display("errors: %0d assertion failures, %0d timeouts", fails, timeouts);
		if (fails == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	// run limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < max_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: done never arrived");
		close_run(1);
	end

	initial begin
		bm_data_t blk;
		bm_data_t blk_b;
		start = 1'b0;
		data_in = '0;
		lfsr_state = 32'h8776;
		wait (reset_n);
		// quiet window after reset
		repeat (4) @(negedge clk);
		run_block('0);
		repeat (3) @(negedge clk);
		for (int n = 0; n < num_random; n++) begin
			random_block(blk);
			run_block(blk);
			repeat (3) @(negedge clk);
		end
		// second start lands mid-run and must be dropped
		random_block(blk);
		random_block(blk_b);
		pulse_start(blk);
		repeat (5) @(negedge clk);
		pulse_start(blk_b);
		wait_done();
		// long enough for a stray second done to show up
		repeat (40) @(negedge clk);
		close_run(0);
	end

endmodule

`default_nettype wire

// File: blockmix_clk_gen.sv
// testbench clock (20 ns period) and active-low reset held for the first 4 cycles
`timescale 1ns/1ps
`default_nettype none

module blockmix_clk_gen (
	output logic clk,
	output logic reset_n
);

	localparam int half_period = 10;
	localparam int reset_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: blockmix_asserts.sv
// simulation-only checks for blockmix r = 1; assumes reset before the first start, sim only
`timescale 1ns/1ps
`default_nettype none

`include "blockmix_defs.svh"

module blockmix_asserts
	import blockmix_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input logic start,
	input bm_data_t data_in,
	input bm_data_t data_out,
	input logic done
);

	// start to done, and the last cycle that still shows the old Y0
	localparam logic [4:0] done_lat = 5'd27;
	localparam logic [4:0] upd_lo_lat = 5'd13;

	// quarter-round word sets, diagonal word first
	localparam int col_set [4][4] = '{
		'{0, 4, 8, 12}, '{5, 9, 13, 1}, '{10, 14, 2, 6}, '{15, 3, 7, 11}
	};
	localparam int row_set [4][4] = '{
		'{0, 1, 2, 3}, '{5, 6, 7, 4}, '{10, 11, 8, 9}, '{15, 12, 13, 14}
	};

	logic busy_m;
	logic [4:0] cnt_m;
	logic seen_start;
	logic have_res;
	bm_data_t in_m;
	bm_data_t exp_m;
	bm_data_t held_m;

	int idle_fails = 0;
	int late_fails = 0;
	int missing_fails = 0;
	int pulse_fails = 0;
	int result_fails = 0;
	int zero_fails = 0;
	int hold_fails = 0;
	int fail_cnt;

	assign fail_cnt = idle_fails + late_fails + missing_fails + pulse_fails
		+ result_fails + zero_fails + hold_fails;

	function automatic word_t rotl(word_t w, int n);
		return (w << n) | (w >> (`BM_WORD_W - n));
	endfunction

	function automatic block_t qr(block_t x, int a, int b, int c, int d);
		x[b] = x[b] ^ rotl(x[a] + x[d], `BM_ROT_A);
		x[c] = x[c] ^ rotl(x[b] + x[a], `BM_ROT_B);
		x[d] = x[d] ^ rotl(x[c] + x[b], `BM_ROT_C);
		x[a] = x[a] ^ rotl(x[d] + x[c], `BM_ROT_D);
		return x;
	endfunction

	function automatic block_t salsa8(block_t in);
		block_t x;
		x = in;
		// each pass is one column round and one row round
		for (int dr = 0; dr < `BM_SALSA_ROUNDS / 2; dr++) begin
			for (int q = 0; q < 4; q++) begin
				x = qr(x, col_set[q][0], col_set[q][1], col_set[q][2], col_set[q][3]);
			end
			for (int q = 0; q < 4; q++) begin
				x = qr(x, row_set[q][0], row_set[q][1], row_set[q][2], row_set[q][3]);
			end
		end
		for (int i = 0; i < `BM_BLOCK_WORDS; i++) begin
			x[i] = x[i] + in[i];
		end
		return x;
	endfunction

	function automatic bm_data_t bm_ref(bm_data_t b);
		bm_data_t y;
		y.lo_blk = salsa8(b.lo_blk ^ b.hi_blk);
		y.hi_blk = salsa8(y.lo_blk ^ b.hi_blk);
		return y;
	endfunction

	// model of which start is taken and when done is due
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy_m <= 1'b0;
			cnt_m <= '0;
			seen_start <= 1'b0;
			have_res <= 1'b0;
			in_m <= '0;
			exp_m <= '0;
			held_m <= '0;
		end else begin
			if (start && !busy_m) begin
				busy_m <= 1'b1;
				cnt_m <= 5'd1;
				seen_start <= 1'b1;
				in_m <= data_in;
				exp_m <= bm_ref(data_in);
			end else if (busy_m) begin
				if (cnt_m == done_lat) begin
					busy_m <= 1'b0;
				end else begin
					cnt_m <= cnt_m + 5'd1;
				end
			end
			if (done) begin
				held_m <= data_out;
				have_res <= 1'b1;
			end
		end
	end

	idle_out: assert property (@(posedge clk) disable iff (!reset_n)
		!seen_start |-> !done && data_out == '0)
		else begin
			idle_fails++;
			$error("ERR %0t: done or data_out not zero before the first start", $time);
		end

	done_on_time: assert property (@(posedge clk) disable iff (!reset_n)
		done |-> busy_m && cnt_m == done_lat)
		else begin
			late_fails++;
			$error("ERR %0t: done without a start 27 cycles before", $time);
		end

	done_due: assert property (@(posedge clk) disable iff (!reset_n)
		busy_m && cnt_m == done_lat |-> done)
		else begin
			missing_fails++;
			$error("ERR %0t: done missing 27 cycles after start", $time);
		end

	done_single: assert property (@(posedge clk) disable iff (!reset_n)
		done |=> !done)
		else begin
			pulse_fails++;
			$error("ERR %0t: done high for two cycles", $time);
		end

	result_ok: assert property (@(posedge clk) disable iff (!reset_n)
		done |-> data_out == exp_m)
		else begin
			result_fails++;
			$error("ERR %0t: data_out differs from reference blockmix", $time);
		end

	zero_in_zero_out: assert property (@(posedge clk) disable iff (!reset_n)
		done && in_m == '0 |-> data_out == '0)
		else begin
			zero_fails++;
			$error("ERR %0t: zero block did not give a zero result", $time);
		end

	// old result stays until the next run overwrites Y0
	result_held: assert property (@(posedge clk) disable iff (!reset_n)
		have_res && (!busy_m || cnt_m <= upd_lo_lat) |-> data_out == held_m)
		else begin
			hold_fails++;
			$error("ERR %0t: data_out changed between done and the next upd_lo", $time);
		end

endmodule

bind blockmix blockmix_asserts asserts_inst (
	.clk(clk),
	.reset_n(reset_n),
	.start(start),
	.data_in(data_in),
	.data_out(data_out),
	.done(done)
);

`default_nettype wire

// File: blockmix.sv
// scrypt blockmix top, r = 1; one block at a time, data_out valid from done until the next run
`timescale 1ns/1ps
`default_nettype none

module blockmix
	import blockmix_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input logic start,
	input bm_data_t data_in,
	output bm_data_t data_out,
	output logic done
);

	dp_ctrl_t dp_ctrl;
	logic salsa_init;
	logic salsa_valid;
	block_t xor_blk;
	block_t salsa_blk;

	blockmix_ctrl ctrl_inst (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.salsa_valid(salsa_valid),
		.dp_ctrl(dp_ctrl),
		.salsa_init(salsa_init),
		.done(done)
	);

	blockmix_dp dp_inst (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(dp_ctrl),
		.data_in(data_in),
		.salsa_blk(salsa_blk),
		.xor_blk(xor_blk),
		.data_out(data_out)
	);

	salsa_core core_inst (
		.clk(clk),
		.reset_n(reset_n),
		.init(salsa_init),
		.xor_blk(xor_blk),
		.salsa_blk(salsa_blk),
		.salsa_valid(salsa_valid)
	);

endmodule

`default_nettype wire

// File: blockmix_ctrl.sv
// blockmix sequencer; start is only taken in IDLE and done comes 27 cycles later, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module blockmix_ctrl
	import blockmix_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input logic start,
	input logic salsa_valid,
	output dp_ctrl_t dp_ctrl,
	output logic salsa_init,
	output logic done
);

	bm_state_t state_q;
	bm_state_t state_d;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start) begin
					state_d = XOR0;
				end
			end
			XOR0: state_d = INIT0;
			INIT0: state_d = RUN0;
			RUN0: begin
				if (salsa_valid) begin
					state_d = SUM0;
				end
			end
			SUM0: state_d = UPD0;
			UPD0: state_d = XOR1;
			XOR1: state_d = INIT1;
			INIT1: state_d = RUN1;
			RUN1: begin
				if (salsa_valid) begin
					state_d = SUM1;
				end
			end
			SUM1: state_d = UPD1;
			UPD1: state_d = DONE;
			DONE: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	// strobes decoded from state
	always_comb begin
		dp_ctrl = '0;
		// input capture in the start cycle itself
		dp_ctrl.in_en = (state_q == IDLE) && start;
		dp_ctrl.xor_en = (state_q == XOR0) || (state_q == XOR1);
		dp_ctrl.sel_prev = (state_q == XOR1);
		dp_ctrl.sum_en = (state_q == SUM0) || (state_q == SUM1);
		dp_ctrl.upd_lo = (state_q == UPD0);
		dp_ctrl.upd_hi = (state_q == UPD1);
	end

	assign salsa_init = (state_q == INIT0) || (state_q == INIT1);
	assign done = (state_q == DONE);

endmodule

`default_nettype wire

// File: blockmix_dp.sv
// blockmix r = 1 datapath; registers only move on their strobe, sequencing is up to the controller
`timescale 1ns/1ps
`default_nettype none

`include "blockmix_defs.svh"

module blockmix_dp
	import blockmix_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input dp_ctrl_t ctrl,
	input bm_data_t data_in,
	input block_t salsa_blk,
	output block_t xor_blk,
	output bm_data_t data_out
);

	bm_data_t in_q;
	block_t sum_q;
	block_t xor_src;
	block_t sum_d;

	// B0 on the first pass, Y0 on the second
	assign xor_src = ctrl.sel_prev ? sum_q : in_q.lo_blk;

	// salsa feed-forward
	always_comb begin
		for (int i = 0; i < `BM_BLOCK_WORDS; i++) begin
			sum_d[i] = xor_blk[i] + salsa_blk[i];
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			in_q <= '0;
		end else if (ctrl.in_en) begin
			in_q <= data_in;
		end
	end

	// always mixed with B1
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			xor_blk <= '0;
		end else if (ctrl.xor_en) begin
			xor_blk <= xor_src ^ in_q.hi_blk;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sum_q <= '0;
		end else if (ctrl.sum_en) begin
			sum_q <= sum_d;
		end
	end

	// output halves load separately, Y0 then Y1
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			data_out.lo_blk <= '0;
		end else if (ctrl.upd_lo) begin
			data_out.lo_blk <= sum_q;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			data_out.hi_blk <= '0;
		end else if (ctrl.upd_hi) begin
			data_out.hi_blk <= sum_q;
		end
	end

endmodule

`default_nettype wire

// File: salsa_core.sv
// iterative salsa20/8 without feed-forward; valid 9 cycles after init, result held until next init
`timescale 1ns/1ps
`default_nettype none

`include "blockmix_defs.svh"

module salsa_core
	import blockmix_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input logic init,
	input block_t xor_blk,
	output block_t salsa_blk,
	output logic salsa_valid
);

	localparam int rnd_w = $clog2(`BM_SALSA_ROUNDS);

	logic [rnd_w-1:0] rnd;
	logic busy;
	logic last_rnd;
	block_t round_out;

	// even rounds are column rounds
	salsa_round round_inst (
		.blk_in(salsa_blk),
		.row_round(rnd[0]),
		.blk_out(round_out)
	);

	assign last_rnd = (rnd == rnd_w'(`BM_SALSA_ROUNDS - 1));

	// working state doubles as the result
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			salsa_blk <= '0;
		end else if (init) begin
			salsa_blk <= xor_blk;
		end else if (busy) begin
			salsa_blk <= round_out;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rnd <= '0;
			busy <= 1'b0;
		end else if (init) begin
			rnd <= '0;
			busy <= 1'b1;
		end else if (busy) begin
			rnd <= rnd + 1'b1;
			if (last_rnd) begin
				busy <= 1'b0;
			end
		end
	end

	// one-cycle pulse right after the last round lands
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			salsa_valid <= 1'b0;
		end else begin
			salsa_valid <= busy && last_rnd && !init;
		end
	end

endmodule

`default_nettype wire

// File: salsa_round.sv
// one salsa column or row round, purely combinational; the four quarter-rounds are independent
`timescale 1ns/1ps
`default_nettype none

`include "blockmix_defs.svh"

module salsa_round
	import blockmix_pkg::*;
(
	input block_t blk_in,
	input logic row_round,
	output block_t blk_out
);

	function automatic word_t rotl(word_t w, int n);
		return (w << n) | (w >> (`BM_WORD_W - n));
	endfunction

	// word j of quarter-round q
	function automatic int word_pos(int q, int j, logic row);
		if (row) begin
			return 4 * q + (q + j) % 4;
		end
		return (5 * q + 4 * j) % `BM_BLOCK_WORDS;
	endfunction

	// b[i0] is the diagonal word, updated last
	function automatic block_t quarter(block_t b, int i0, int i1, int i2, int i3);
		block_t r;
		r = b;
		r[i1] = b[i1] ^ rotl(b[i0] + b[i3], `BM_ROT_A);
		r[i2] = b[i2] ^ rotl(r[i1] + b[i0], `BM_ROT_B);
		r[i3] = b[i3] ^ rotl(r[i2] + r[i1], `BM_ROT_C);
		r[i0] = b[i0] ^ rotl(r[i3] + r[i2], `BM_ROT_D);
		return r;
	endfunction

	always_comb begin
		block_t t;
		t = blk_in;
		// disjoint word sets, so applying them one after another is exact
		for (int q = 0; q < 4; q++) begin
			t = quarter(t,
				word_pos(q, 0, row_round),
				word_pos(q, 1, row_round),
				word_pos(q, 2, row_round),
				word_pos(q, 3, row_round));
		end
		blk_out = t;
	end

endmodule

`default_nettype wire

// File: blockmix_pkg.sv
// types for the r = 1 blockmix engine; word 0 of a block sits in the low bits
`default_nettype none

`include "blockmix_defs.svh"

package blockmix_pkg;

	typedef logic [`BM_WORD_W-1:0] word_t;

	// 64-byte salsa block
	typedef word_t [`BM_BLOCK_WORDS-1:0] block_t;

	// block 0 in the low half, as in scrypt
	typedef struct packed {
		block_t hi_blk;
		block_t lo_blk;
	} bm_data_t;

	// datapath strobes, each one cycle wide
	typedef struct packed {
		logic in_en;
		logic sel_prev;
		logic xor_en;
		logic sum_en;
		logic upd_lo;
		logic upd_hi;
	} dp_ctrl_t;

	typedef enum logic [3:0] {
		IDLE, XOR0, INIT0, RUN0, SUM0, UPD0,
		XOR1, INIT1, RUN1, SUM1, UPD1, DONE
	} bm_state_t;

endpackage

`default_nettype wire

// File: blockmix_defs.svh
// fixed salsa20/8 geometry for scrypt blockmix with r = 1; other values are not a valid salsa
`ifndef BLOCKMIX_DEFS_SVH
`define BLOCKMIX_DEFS_SVH

// word and block geometry
`define BM_WORD_W 32
`define BM_BLOCK_WORDS 16

// column and row rounds alternate, so this must stay even
`define BM_SALSA_ROUNDS 8

// quarter-round rotate amounts, in order of use
`define BM_ROT_A 7
`define BM_ROT_B 9
`define BM_ROT_C 13
`define BM_ROT_D 18

`endif
